/* rtl/ros2_buf_pkg.sv */
package ros2_buf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Grant and owner encodings
    // ~~~~~~~~~~~~~~~~~~~~

    // App-data region, one bit per party plus idle
    typedef enum logic [1:0] {
        NONE = 2'b00,
        IP   = 2'b01,
        CPU  = 2'b10
    } app_grant_e;

    // UDP buffers always have exactly one owner
    typedef enum logic {
        OWNER_IP  = 1'b0,
        OWNER_CPU = 1'b1
    } buf_owner_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Widths and depths
    // ~~~~~~~~~~~~~~~~~~~~

    // Word address into a UDP buffer
    localparam int BUF_ADDR_W = 6;
    localparam int BUF_WORD_W = 32;

    // Byte stream between protocol core and IP engines
    localparam int FIFO_BYTE_W   = 8;
    localparam int TX_FIFO_DEPTH = 16;
    localparam int RX_FIFO_DEPTH = 8;

endpackage

/* rtl/ros2_msg_pkg.sv */
package ros2_msg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // CPU transmit message
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int MSG_WORDS = 5;

    // Little-endian words as the protocol core reads them
    // Dest IP, dest/src UDP port, payload length, payload text
    localparam logic [ros2_buf_pkg::BUF_WORD_W-1:0] MSG_TABLE [MSG_WORDS] = '{
        32'h0a01a8c0,
        32'h045704d2,
        32'h00000007,
        32'h626f6f66,
        32'h000a7261
    };

    // ~~~~~~~~~~~~~~~~~~~~
    // Release timer
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int REL_CNT_W = 6;

    // Timer counts up to its top bit, then clears on the pulse
    localparam int REL_PERIOD = (2 ** (REL_CNT_W - 1)) + 1;

endpackage

/* rtl/app_data_arbiter.sv */
`timescale 1ns/100ps

module app_data_arbiter (
    input  logic clk_int,
    input  logic rst_int,
    input  logic ip_req,
    input  logic cpu_req,
    input  logic ip_rel,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    import ros2_buf_pkg::*;

    app_grant_e state;

    // Requests only count while idle, IP wins a tie
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state <= NONE;
        end else begin
            case (state)
                NONE: begin
                    if (ip_req) begin
                        state <= IP;
                    end else if (cpu_req) begin
                        state <= CPU;
                    end
                end
                IP: begin
                    if (ip_rel) begin
                        state <= NONE;
                    end
                end
                CPU: begin
                    if (cpu_rel) begin
                        state <= NONE;
                    end
                end
                default: begin
                    state <= NONE;
                end
            endcase
        end
    end

    assign ip_grant  = (state == IP);
    assign cpu_grant = (state == CPU);

    // At most one party holds the region
    a_grant_excl: assert property (@(posedge clk_int) disable iff (rst_int)
        !(ip_grant && cpu_grant));

endmodule

/* rtl/buf_owner.sv */
`timescale 1ns/100ps

module buf_owner #(
    parameter ros2_buf_pkg::buf_owner_e reset_owner = ros2_buf_pkg::OWNER_IP
) (
    input  logic clk_int,
    input  logic rst_int,
    input  logic ip_rel,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    import ros2_buf_pkg::*;

    buf_owner_e owner;

    // Only the current owner can hand the buffer over
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            owner <= reset_owner;
        end else begin
            case (owner)
                OWNER_IP: begin
                    if (ip_rel) begin
                        owner <= OWNER_CPU;
                    end
                end
                default: begin
                    if (cpu_rel) begin
                        owner <= OWNER_IP;
                    end
                end
            endcase
        end
    end

    assign ip_grant  = (owner == OWNER_IP);
    assign cpu_grant = (owner == OWNER_CPU);

    a_one_owner: assert property (@(posedge clk_int) disable iff (rst_int)
        $onehot({ip_grant, cpu_grant}));

endmodule

/* rtl/byte_fifo.sv */
`timescale 1ns/100ps

module byte_fifo #(
    parameter int depth = 16
) (
    input  logic                                 clk_int,
    input  logic                                 rst_int,
    input  logic                                 wr_en,
    input  logic [ros2_buf_pkg::FIFO_BYTE_W-1:0] din,
    input  logic                                 rd_en,
    output logic [ros2_buf_pkg::FIFO_BYTE_W-1:0] dout,
    output logic                                 full,
    output logic                                 empty
);

    import ros2_buf_pkg::*;

    logic [FIFO_BYTE_W-1:0]     mem [depth];
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       do_wr;
    logic                       do_rd;

    // Writes while full and reads while empty are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk_int) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                if (int'(wr_ptr) == depth - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_rd) begin
                if (int'(rd_ptr) == depth - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Show-ahead, head entry always on dout
    assign dout  = mem[rd_ptr];
    assign full  = (int'(count) == depth);
    assign empty = (count == '0);

    a_count_bound: assert property (@(posedge clk_int) disable iff (rst_int)
        int'(count) <= depth);

endmodule

/* rtl/txbuf_msg_source.sv */
`timescale 1ns/100ps

module txbuf_msg_source (
    input  logic                                clk_int,
    input  logic                                rst_int,
    input  logic [ros2_buf_pkg::BUF_ADDR_W-1:0] addr,
    output logic [ros2_buf_pkg::BUF_WORD_W-1:0] rdata,
    output logic                                cpu_rel
);

    import ros2_buf_pkg::*;
    import ros2_msg_pkg::*;

    logic [$clog2(MSG_WORDS)-1:0] tbl_idx;
    logic                         in_table;
    logic [REL_CNT_W-1:0]         rel_cnt;

    assign tbl_idx  = addr[$clog2(MSG_WORDS)-1:0];
    assign in_table = (addr < BUF_ADDR_W'(MSG_WORDS));

    // ~~~~~~~~~~~~~~~~~~~~
    // Word table read port
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            rdata <= '0;
        end else if (in_table) begin
            rdata <= MSG_TABLE[tbl_idx];
        end else begin
            rdata <= '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Periodic release
    // ~~~~~~~~~~~~~~~~~~~~

    // Pulse and restart once the top bit comes up
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            rel_cnt <= '0;
            cpu_rel <= 1'b0;
        end else if (rel_cnt[REL_CNT_W-1]) begin
            rel_cnt <= '0;
            cpu_rel <= 1'b1;
        end else begin
            rel_cnt <= rel_cnt + 1'b1;
            cpu_rel <= 1'b0;
        end
    end

    a_rel_single: assert property (@(posedge clk_int) disable iff (rst_int)
        cpu_rel |=> !cpu_rel);

endmodule

/* rtl/ros2_buf_share.sv */
`timescale 1ns/100ps

module ros2_buf_share (
    input  logic                                 clk_int,
    input  logic                                 rst_int,

    // App-data region
    input  logic                                 app_data_ip_req,
    input  logic                                 app_data_cpu_req,
    input  logic                                 app_data_ip_rel,
    input  logic                                 app_data_cpu_rel,
    output logic                                 app_data_ip_grant,
    output logic                                 app_data_cpu_grant,

    // UDP receive buffer
    input  logic                                 udp_rxbuf_ip_rel,
    input  logic                                 udp_rxbuf_cpu_rel,
    output logic                                 udp_rxbuf_ip_grant,
    output logic                                 udp_rxbuf_cpu_grant,

    // UDP transmit buffer
    input  logic                                 udp_txbuf_ip_rel,
    output logic                                 udp_txbuf_ip_grant,
    output logic                                 udp_txbuf_cpu_grant,
    input  logic [ros2_buf_pkg::BUF_ADDR_W-1:0]  udp_txbuf_addr,
    output logic [ros2_buf_pkg::BUF_WORD_W-1:0]  udp_txbuf_rdata,

    // Core to IP transmit engine
    input  logic                                 tx_fifo_wr_en,
    input  logic [ros2_buf_pkg::FIFO_BYTE_W-1:0] tx_fifo_din,
    output logic                                 tx_fifo_full,
    input  logic                                 tx_fifo_rd_en,
    output logic [ros2_buf_pkg::FIFO_BYTE_W-1:0] tx_fifo_dout,
    output logic                                 tx_fifo_empty,

    // IP receive engine to core
    input  logic                                 rx_fifo_wr_en,
    input  logic [ros2_buf_pkg::FIFO_BYTE_W-1:0] rx_fifo_din,
    output logic                                 rx_fifo_full,
    input  logic                                 rx_fifo_rd_en,
    output logic [ros2_buf_pkg::FIFO_BYTE_W-1:0] rx_fifo_dout,
    output logic                                 rx_fifo_empty
);

    import ros2_buf_pkg::*;

    // Timer pulse from the CPU side
    logic txbuf_cpu_rel;

    app_data_arbiter app_arb_i (
        .clk_int   (clk_int),
        .rst_int   (rst_int),
        .ip_req    (app_data_ip_req),
        .cpu_req   (app_data_cpu_req),
        .ip_rel    (app_data_ip_rel),
        .cpu_rel   (app_data_cpu_rel),
        .ip_grant  (app_data_ip_grant),
        .cpu_grant (app_data_cpu_grant)
    );

    // Receive buffer starts with the IP side
    buf_owner #(
        .reset_owner (OWNER_IP)
    ) rxbuf_owner_i (
        .clk_int   (clk_int),
        .rst_int   (rst_int),
        .ip_rel    (udp_rxbuf_ip_rel),
        .cpu_rel   (udp_rxbuf_cpu_rel),
        .ip_grant  (udp_rxbuf_ip_grant),
        .cpu_grant (udp_rxbuf_cpu_grant)
    );

    // Transmit buffer starts with the CPU, which loads the message
    buf_owner #(
        .reset_owner (OWNER_CPU)
    ) txbuf_owner_i (
        .clk_int   (clk_int),
        .rst_int   (rst_int),
        .ip_rel    (udp_txbuf_ip_rel),
        .cpu_rel   (txbuf_cpu_rel),
        .ip_grant  (udp_txbuf_ip_grant),
        .cpu_grant (udp_txbuf_cpu_grant)
    );

    byte_fifo #(
        .depth (TX_FIFO_DEPTH)
    ) tx_fifo_i (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .wr_en   (tx_fifo_wr_en),
        .din     (tx_fifo_din),
        .rd_en   (tx_fifo_rd_en),
        .dout    (tx_fifo_dout),
        .full    (tx_fifo_full),
        .empty   (tx_fifo_empty)
    );

    byte_fifo #(
        .depth (RX_FIFO_DEPTH)
    ) rx_fifo_i (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .wr_en   (rx_fifo_wr_en),
        .din     (rx_fifo_din),
        .rd_en   (rx_fifo_rd_en),
        .dout    (rx_fifo_dout),
        .full    (rx_fifo_full),
        .empty   (rx_fifo_empty)
    );

    txbuf_msg_source msg_src_i (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .addr    (udp_txbuf_addr),
        .rdata   (udp_txbuf_rdata),
        .cpu_rel (txbuf_cpu_rel)
    );

endmodule

/* tb/tb_ros2_buf_share.sv */
`timescale 1ns/100ps

module tb_ros2_buf_share;

    import ros2_buf_pkg::*;
    import ros2_msg_pkg::*;

    logic clk_int;
    logic rst_int;
    logic app_data_ip_req, app_data_cpu_req, app_data_ip_rel, app_data_cpu_rel;
    logic app_data_ip_grant, app_data_cpu_grant;
    logic udp_rxbuf_ip_rel, udp_rxbuf_cpu_rel, udp_rxbuf_ip_grant, udp_rxbuf_cpu_grant;
    logic udp_txbuf_ip_rel, udp_txbuf_ip_grant, udp_txbuf_cpu_grant;
    logic [BUF_ADDR_W-1:0]  udp_txbuf_addr;
    logic [BUF_WORD_W-1:0]  udp_txbuf_rdata;
    logic tx_fifo_wr_en, tx_fifo_rd_en, tx_fifo_full, tx_fifo_empty;
    logic rx_fifo_wr_en, rx_fifo_rd_en, rx_fifo_full, rx_fifo_empty;
    logic [FIFO_BYTE_W-1:0] tx_fifo_din, tx_fifo_dout, rx_fifo_din, rx_fifo_dout;

    // Reference state, stepped on the same edges as the DUT
    app_grant_e             ref_grant;
    buf_owner_e             ref_rx_owner;
    buf_owner_e             ref_tx_owner;
    logic                   ref_pulse;
    int                     rel_cycles;
    logic [BUF_WORD_W-1:0]  ref_rdata;
    logic [FIFO_BYTE_W-1:0] tx_q[$];
    logic [FIFO_BYTE_W-1:0] rx_q[$];
    bit                     model_live = 1'b0;
    int                     mismatches = 0;

    ros2_buf_share dut_i (.*);

    initial begin
        clk_int = 1'b0;
        forever #20 clk_int = ~clk_int;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference functions
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic app_grant_e next_grant(app_grant_e cur, logic ip_req, logic cpu_req,
                                              logic ip_rel, logic cpu_rel);
        if (cur == IP) begin
            return ip_rel ? NONE : IP;
        end else if (cur == CPU) begin
            return cpu_rel ? NONE : CPU;
        end else if (ip_req) begin
            return IP;
        end
        return cpu_req ? CPU : NONE;
    endfunction

    function automatic buf_owner_e next_owner(buf_owner_e cur, logic ip_rel, logic cpu_rel);
        if (cur == OWNER_IP && ip_rel) begin
            return OWNER_CPU;
        end else if (cur == OWNER_CPU && cpu_rel) begin
            return OWNER_IP;
        end
        return cur;
    endfunction

    function automatic logic [BUF_WORD_W-1:0] table_word(logic [BUF_ADDR_W-1:0] addr);
        logic [$clog2(MSG_WORDS)-1:0] idx;

        idx = addr[$clog2(MSG_WORDS)-1:0];
        if (int'(addr) < MSG_WORDS) begin
            return MSG_TABLE[idx];
        end
        return '0;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic stop_on_failure(string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_mismatch(string msg);
        mismatches++;
        stop_on_failure($sformatf("FAILED at %0t: %s", $time, msg));
    endtask

    task automatic check_grant(string what, app_grant_e got, app_grant_e exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %s", what, got, exp.name()));
        end
    endtask

    task automatic check_owner(string what, logic ip_grant, logic cpu_grant, buf_owner_e exp);
        buf_owner_e got;

        if (ip_grant === cpu_grant) begin
            report_mismatch($sformatf("%s grants ip=%b cpu=%b, expected exactly one",
                                      what, ip_grant, cpu_grant));
        end
        got = cpu_grant ? OWNER_CPU : OWNER_IP;
        if (got !== exp) begin
            report_mismatch($sformatf("%s owned by %s, expected %s", what, got.name(),
                                      exp.name()));
        end
    endtask

    task automatic check_word(string what, logic [BUF_WORD_W-1:0] got,
                              logic [BUF_WORD_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_byte(string what, logic [FIFO_BYTE_W-1:0] got,
                              logic [FIFO_BYTE_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic chance(int pct);
        return int'($urandom % 100) < pct;
    endfunction

    task automatic drive_cycle(int wr_pct, int rd_pct);
        @(posedge clk_int);
        app_data_ip_req   <= chance(30);
        app_data_cpu_req  <= chance(30);
        app_data_ip_rel   <= chance(30);
        app_data_cpu_rel  <= chance(30);
        udp_rxbuf_ip_rel  <= chance(20);
        udp_rxbuf_cpu_rel <= chance(20);
        udp_txbuf_ip_rel  <= chance(5);
        udp_txbuf_addr    <= BUF_ADDR_W'($urandom);
        tx_fifo_wr_en     <= chance(wr_pct);
        tx_fifo_din       <= FIFO_BYTE_W'($urandom);
        tx_fifo_rd_en     <= chance(rd_pct);
        rx_fifo_wr_en     <= chance(wr_pct);
        rx_fifo_din       <= FIFO_BYTE_W'($urandom);
        rx_fifo_rd_en     <= chance(rd_pct);
    endtask

    task automatic wait_tx_owner(logic want_ip, int limit, string what, output int edges);
        edges = 0;
        do begin
            @(posedge clk_int);
            edges++;
            @(negedge clk_int);
        end while (udp_txbuf_ip_grant !== want_ip && edges < limit);
        if (udp_txbuf_ip_grant !== want_ip) begin
            stop_on_failure($sformatf("Timed out waiting for %s", what));
        end
    endtask

    task automatic fifo_phase(int wr_pct, int rd_pct, logic want_full, string what);
        int   n;
        logic done;

        n = 0;
        done = 1'b0;
        while (!done && n < 200) begin
            drive_cycle(wr_pct, rd_pct);
            @(negedge clk_int);
            n++;
            if (want_full) begin
                done = tx_fifo_full && rx_fifo_full;
            end else begin
                done = tx_fifo_empty && rx_fifo_empty;
            end
        end
        if (!done) begin
            stop_on_failure($sformatf("Timed out waiting for %s", what));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference and compare
    // ~~~~~~~~~~~~~~~~~~~~

    // Inputs read here are the values the DUT samples on this edge
    always @(posedge clk_int) begin
        logic tx_push;
        logic rx_push;

        tx_push = tx_fifo_wr_en && (tx_q.size() < TX_FIFO_DEPTH);
        rx_push = rx_fifo_wr_en && (rx_q.size() < RX_FIFO_DEPTH);
        if (rst_int) begin
            ref_grant    = NONE;
            ref_rx_owner = OWNER_IP;
            ref_tx_owner = OWNER_CPU;
            ref_pulse    = 1'b0;
            rel_cycles   = 0;
            ref_rdata    = '0;
            tx_q.delete();
            rx_q.delete();
            model_live   = 1'b1;
        end else begin
            ref_grant = next_grant(ref_grant, app_data_ip_req, app_data_cpu_req,
                                   app_data_ip_rel, app_data_cpu_rel);
            ref_rx_owner = next_owner(ref_rx_owner, udp_rxbuf_ip_rel, udp_rxbuf_cpu_rel);
            // Owner sees the pulse from the previous cycle
            ref_tx_owner = next_owner(ref_tx_owner, udp_txbuf_ip_rel, ref_pulse);
            rel_cycles++;
            ref_pulse = (rel_cycles % REL_PERIOD) == 0;
            ref_rdata = table_word(udp_txbuf_addr);
            if (tx_fifo_rd_en && tx_q.size() > 0) begin
                void'(tx_q.pop_front());
            end
            if (tx_push) begin
                tx_q.push_back(tx_fifo_din);
            end
            if (rx_fifo_rd_en && rx_q.size() > 0) begin
                void'(rx_q.pop_front());
            end
            if (rx_push) begin
                rx_q.push_back(rx_fifo_din);
            end
        end
    end

    always @(negedge clk_int) begin
        if (model_live) begin
            check_grant("app-data grant",
                        app_grant_e'({app_data_cpu_grant, app_data_ip_grant}), ref_grant);
            check_owner("rx buffer", udp_rxbuf_ip_grant, udp_rxbuf_cpu_grant, ref_rx_owner);
            check_owner("tx buffer", udp_txbuf_ip_grant, udp_txbuf_cpu_grant, ref_tx_owner);
            check_word("udp_txbuf_rdata", udp_txbuf_rdata, ref_rdata);
            check_flag("tx_fifo_empty", tx_fifo_empty, tx_q.size() == 0);
            check_flag("tx_fifo_full", tx_fifo_full, tx_q.size() == TX_FIFO_DEPTH);
            check_flag("rx_fifo_empty", rx_fifo_empty, rx_q.size() == 0);
            check_flag("rx_fifo_full", rx_fifo_full, rx_q.size() == RX_FIFO_DEPTH);
            if (tx_q.size() > 0) begin
                check_byte("tx_fifo_dout", tx_fifo_dout, tx_q[0]);
            end
            if (rx_q.size() > 0) begin
                check_byte("rx_fifo_dout", rx_fifo_dout, rx_q[0]);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        int edges;

        void'($urandom(32'h7132_8e21));
        rst_int           = 1'b1;
        app_data_ip_req   = 1'b0;
        app_data_cpu_req  = 1'b0;
        app_data_ip_rel   = 1'b0;
        app_data_cpu_rel  = 1'b0;
        udp_rxbuf_ip_rel  = 1'b0;
        udp_rxbuf_cpu_rel = 1'b0;
        udp_txbuf_ip_rel  = 1'b0;
        udp_txbuf_addr    = '0;
        tx_fifo_wr_en     = 1'b0;
        tx_fifo_din       = '0;
        tx_fifo_rd_en     = 1'b0;
        rx_fifo_wr_en     = 1'b0;
        rx_fifo_din       = '0;
        rx_fifo_rd_en     = 1'b0;
        repeat (16) @(posedge clk_int);
        rst_int <= 1'b0;

        // First timer pulse hands the tx buffer to IP
        wait_tx_owner(1'b1, 3 * REL_PERIOD, "the first tx buffer handoff to IP", edges);
        if (edges != REL_PERIOD + 1) begin
            report_mismatch($sformatf("tx buffer reached IP after %0d edges, expected %0d",
                                      edges, REL_PERIOD + 1));
        end
        @(posedge clk_int);
        udp_txbuf_ip_rel <= 1'b1;
        wait_tx_owner(1'b0, 4, "the tx buffer return to the CPU", edges);
        @(posedge clk_int);
        udp_txbuf_ip_rel <= 1'b0;
        wait_tx_owner(1'b1, 2 * REL_PERIOD, "the second tx buffer handoff to IP", edges);

        // Random traffic, FIFOs pushed to both limits
        repeat (200) drive_cycle(50, 50);
        fifo_phase(90, 0, 1'b1, "both FIFOs to fill");
        repeat (8) drive_cycle(100, 0);
        fifo_phase(0, 90, 1'b0, "both FIFOs to drain");
        repeat (8) drive_cycle(0, 100);
        repeat (300) drive_cycle(60, 40);
        repeat (4) @(posedge clk_int);

        if (mismatches == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_on_failure("Mismatches were counted during the run");
        end
    end

endmodule

/* flist.f */
rtl/ros2_buf_pkg.sv
rtl/ros2_msg_pkg.sv
rtl/app_data_arbiter.sv
rtl/buf_owner.sv
rtl/byte_fifo.sv
rtl/txbuf_msg_source.sv
rtl/ros2_buf_share.sv
tb/tb_ros2_buf_share.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_ros2_buf_share -f flist.f

out=$(./obj_dir/Vtb_ros2_buf_share 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
